/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mcpu_core_tb
FILELIST = files.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD)

/* files.f */
verilog/mcpu_pkg.sv
verilog/inst_decode.sv
verilog/mul_ucode.sv
verilog/issue_select.sv
verilog/exec_stage.sv
verilog/mcpu_core_top.sv
verif/mcpu_core_assertions.sv
verif/mcpu_core_tb.sv

/* verif/mcpu_core_assertions.sv */
/*
 * Bound checks on the stall and release pulse, issue select and reset
 */
`timescale 1ns/1ps

module mcpu_core_assertions (
    input logic                clk,
    input logic                rst,
    input logic                instr_stall,
    input logic                mul_release,
    input logic                mux_ctrl,
    input logic                wb_en,
    input mcpu_pkg::uc_state_t uc_state
);

    // Release is a single-cycle pulse
    release_pulse: assert property (@(posedge clk) disable iff (rst)
        mul_release |=> !mul_release)
        else $error("mul_release high for more than one cycle");

    // Sequencer owns the mux only outside idle
    idle_mux: assert property (@(posedge clk) disable iff (rst)
        (uc_state == mcpu_pkg::st_idle) |-> !mux_ctrl)
        else $error("mux_ctrl high while the sequencer is idle");

    stall_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(instr_stall) |-> $past(mul_release))
        else $error("instr_stall fell without a preceding mul_release");

    reset_quiet: assert property (@(posedge clk) rst |-> !wb_en)
        else $error("wb_en high during reset");

endmodule

bind mcpu_core_top mcpu_core_assertions mcpu_core_assertions_i (
    .clk, .rst, .instr_stall, .mul_release, .mux_ctrl, .wb_en,
    .uc_state(mul_ucode_i.state)
);

/* verif/mcpu_core_tb.sv */
/*
 * Testbench for the multiply core slice
 * Each table row seeds operands, sets flags with ADDS, multiplies and holds a trailing ADD
 */
`timescale 1ns/1ps

module mcpu_core_tb;

    localparam int n_rows = 10;
    localparam int tmo    = 200;             // Cycles allowed per wait
    localparam logic [3:0] m_reg = 4'd3;     // Multiplier register in every row
    localparam logic [3:0] h_reg = 4'd9;     // Target of the held word
    localparam logic [3:0] f_reg = 4'd10;    // Target of the flag-setting ADDS

    // Row fields are kind, NOT on r3, random multiplicand, rd, rs1, multiplicand, multiplier
    localparam logic [43:0] rows [n_rows] = '{
        {mcpu_pkg::muli,  1'b0, 1'b0, 4'd1, 4'd2, 16'd7,  16'd0},    // Zero multiplier
        {mcpu_pkg::muli,  1'b0, 1'b0, 4'd1, 4'd2, 16'd9,  16'd1},
        {mcpu_pkg::muli,  1'b0, 1'b1, 4'd4, 4'd5, 16'd0,  16'd5},
        {mcpu_pkg::mulr,  1'b0, 1'b0, 4'd6, 4'd7, 16'd13, 16'd0},
        {mcpu_pkg::mulr,  1'b0, 1'b1, 4'd1, 4'd4, 16'd0,  16'd6},
        {mcpu_pkg::mulsi, 1'b0, 1'b0, 4'd2, 4'd8, 16'd11, 16'hfffd}, // Immediate -3
        {mcpu_pkg::mulsi, 1'b0, 1'b1, 4'd5, 4'd6, 16'd0,  16'd4},
        {mcpu_pkg::mulsr, 1'b1, 1'b0, 4'd7, 4'd1, 16'd21, 16'd2},    // r3 = ~2 = -3
        {mcpu_pkg::mulsr, 1'b1, 1'b1, 4'd8, 4'd2, 16'd0,  16'd0},    // r3 = -1
        {mcpu_pkg::mulsr, 1'b0, 1'b0, 4'd4, 4'd5, 16'd3,  16'd0}
    };

    logic        clk, rst, instr_valid;
    logic [31:0] instr;
    logic        instr_stall, wb_en;
    logic [3:0]  wb_reg, flags;
    logic [31:0] wb_data;

    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    logic [67:0] exp_q [$];    // Ordinary writebacks due as {cycle, reg, value}
    logic [3:0]  cur_rd;
    int          mul_wbs;
    int          mul_last_cyc;
    logic [31:0] mul_last_val;

    mcpu_core_top mcpu_core_top_i (
        .clk, .rst, .instr_valid, .instr, .instr_stall, .wb_en, .wb_reg, .wb_data, .flags
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("TIMEOUT at %0t: %s", $time, why);
        $display("Errors: %0d, checks: %0d", errors + 1, checks);
        $display("Test failed");
        $finish;
    endtask

    // Instruction formats after the field layout
    function automatic logic [31:0] rtype(input logic [6:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2, 13'b0};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, 1'b0, imm};
    endfunction

    // NZCV of x + y
    function automatic logic [3:0] adds_flags(input logic [31:0] x, input logic [31:0] y);
        logic [32:0] s;
        s = {1'b0, x} + {1'b0, y};
        return {s[31], s[31:0] == 32'b0, s[32], (x[31] == y[31]) && (s[31] != x[31])};
    endfunction

    // Drive on the falling edge, hold through the stall, report the accept cycle
    task automatic send_word(input logic [31:0] w, output int acc);
        int n;
        n = 0;
        instr_valid = 1'b1;
        instr = w;
        while (instr_stall && n < tmo) begin
            @(negedge clk);
            n++;
        end
        if (instr_stall) abort_run("instr_stall stayed high with a word waiting");
        @(negedge clk);
        acc = cyc;
        instr_valid = 1'b0;
    endtask

    // Ordinary word written back two cycles after acceptance
    task automatic send_ord(input logic [31:0] w, input logic [3:0] r, input logic [31:0] v,
                            output int acc);
        send_word(w, acc);
        exp_q.push_back({32'(acc + 2), r, v});
    endtask

    task automatic wait_drain(input int want);
        int n;
        n = 0;
        while ((exp_q.size() > 0 || mul_wbs < want || instr_stall) && n < tmo) begin
            @(negedge clk);
            n++;
        end
        if (n >= tmo) abort_run("writebacks of the row did not complete");
        repeat (3) @(negedge clk);    // Room for a late or extra writeback
    endtask

    // Writeback monitor sampled away from the active edge
    always @(negedge clk) begin
        logic [67:0] e;
        e = (exp_q.size() > 0) ? exp_q[0] : '1;
        if (e[67:36] == 32'(cyc)) begin
            void'(exp_q.pop_front());
            assert (wb_en) else begin
                $display("No writeback to r%0d at %0t, due two cycles after accept",
                         e[35:32], $time);
                errors++;
            end
            if (wb_en) begin
                check_value("wb_reg", 32'(e[35:32]), 32'(wb_reg));
                check_value("wb_data", e[31:0], wb_data);
            end
        end else if (wb_en && !rst) begin
            check_value("wb_reg", 32'(cur_rd), 32'(wb_reg));    // Sequenced word
            mul_wbs++;
            mul_last_cyc = cyc;
            mul_last_val = wb_data;
        end
    end

    initial begin
        logic [43:0] row;
        logic [31:0] a, m, mag, prod, r3_val;
        logic [3:0]  rd, rs1, exp_flags;
        logic        imm_form, signed_form;
        int          acc, held_acc, want;
        void'($urandom(32'h95b8_fff8));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = 32'b0;
        cur_rd = 4'd0;
        mul_wbs = 0;
        r3_val = 32'b0;    // Registers clear after reset
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            row = rows[i];
            rd = row[39:36];
            rs1 = row[35:32];
            a = row[40] ? ($urandom & 32'hffff) : {16'b0, row[31:16]};
            imm_form = (row[43:42] == mcpu_pkg::muli) || (row[43:42] == mcpu_pkg::mulsi);
            signed_form = (row[43:42] == mcpu_pkg::mulsi) || (row[43:42] == mcpu_pkg::mulsr);
            // Flags from r3 as the previous row left it
            exp_flags = adds_flags(r3_val, r3_val);
            send_ord(rtype(mcpu_pkg::op_adds, f_reg, m_reg, m_reg), f_reg, r3_val + r3_val, acc);
            send_ord(itype(mcpu_pkg::op_mov, rs1, 4'd0, a[15:0]), rs1, a, acc);
            r3_val = {16'b0, row[15:0]};
            send_ord(itype(mcpu_pkg::op_mov, m_reg, 4'd0, row[15:0]), m_reg, r3_val, acc);
            if (row[41]) begin
                send_ord(rtype(mcpu_pkg::op_not, m_reg, m_reg, 4'd0), m_reg, ~r3_val, acc);
                r3_val = ~r3_val;
            end
            if (imm_form) begin
                m = signed_form ? {{16{row[15]}}, row[15:0]} : {16'b0, row[15:0]};
            end else begin
                m = r3_val;    // Read right after its producer
            end
            mag = (signed_form && m[31]) ? -m : m;
            want = (mag == 0) ? 1 : 1 + int'(mag) + ((signed_form && m[31]) ? 2 : 0);
            prod = a * m;
            cur_rd = rd;
            mul_wbs = 0;
            mul_last_cyc = 0;
            send_word(imm_form ? itype({mcpu_pkg::op_mul_base, row[43:42]}, rd, rs1, row[15:0])
                               : rtype({mcpu_pkg::op_mul_base, row[43:42]}, rd, rs1, m_reg), acc);
            // Stall rises with start_mul, right after the multiply is accepted
            check_value("instr_stall", 32'd1, 32'(instr_stall));
            // Presented during the stall and must see the product
            send_ord(rtype(mcpu_pkg::op_add, h_reg, rd, rd), h_reg, prod + prod, held_acc);
            wait_drain(want);
            check_value("rd writebacks", want, mul_wbs);
            check_value("rd", prod, mul_last_val);
            check_value("flags", 32'(exp_flags), 32'(flags));
            assert (held_acc + 2 > mul_last_cyc) else begin
                $display("Held word in row %0d wrote back before the multiply ended", i);
                errors++;
            end
        end
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/exec_stage.sv */
/*
 * Execute stage with 16x32 register file, ALU and NZCV flag register
 * Second read port serves decode and forwards the result being written
 */
`timescale 1ns/1ps

module exec_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          iss_valid,
    input  logic [31:0]                   iss_instr,
    input  logic [mcpu_pkg::reg_aw-1:0]   src2_reg,
    input  logic [3:0]                    flags_restore,
    input  logic                          flags_restore_en,
    output logic [mcpu_pkg::data_w-1:0]   read_data_second,
    output logic [3:0]                    flags,
    output logic                          wb_en,
    output logic [mcpu_pkg::reg_aw-1:0]   wb_reg,
    output logic [mcpu_pkg::data_w-1:0]   wb_data
);

    localparam int dw = mcpu_pkg::data_w;

    logic [dw-1:0]                 regs [1 << mcpu_pkg::reg_aw];
    logic [6:0]                    opcode;
    logic [mcpu_pkg::reg_aw-1:0]   rd, rs1, rs2;
    logic [dw-1:0]                 a, b, imm_ext;
    logic [dw:0]                   sum; // Carry in the top bit
    logic [dw-1:0]                 result;
    logic                          writes;
    logic                          wr_en;
    logic                          adds_en;

    assign opcode  = iss_instr[mcpu_pkg::op_hi:mcpu_pkg::op_lo];
    assign rd      = iss_instr[mcpu_pkg::rd_hi:mcpu_pkg::rd_lo];
    assign rs1     = iss_instr[mcpu_pkg::rs1_hi:mcpu_pkg::rs1_lo];
    assign rs2     = iss_instr[mcpu_pkg::rs2_hi:mcpu_pkg::rs2_lo];
    assign imm_ext = {{(dw-mcpu_pkg::imm_w){1'b0}}, iss_instr[mcpu_pkg::imm_hi:mcpu_pkg::imm_lo]};
    assign a       = regs[rs1];
    assign b       = regs[rs2];
    assign sum     = {1'b0, a} + {1'b0, b};

    always_comb begin
        result = '0;
        writes = 1'b1;
        case (opcode)
            mcpu_pkg::op_mov:                  result = imm_ext;
            mcpu_pkg::op_add, mcpu_pkg::op_adds: result = sum[dw-1:0];
            mcpu_pkg::op_sub:                  result = a - b;
            mcpu_pkg::op_subi:                 result = a - imm_ext;
            mcpu_pkg::op_not:                  result = ~a;
            default:                           writes = 1'b0; // NOP and unknown
        endcase
    end

    assign wr_en   = iss_valid && writes;
    assign adds_en = iss_valid && (opcode == mcpu_pkg::op_adds);

    // Decode-time read, bypassing the write of this cycle
    assign read_data_second = (wr_en && rd == src2_reg) ? result : regs[src2_reg];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < (1 << mcpu_pkg::reg_aw); i++) regs[i] <= '0;
            flags <= 4'b0;
            wb_en <= 1'b0;
        end else begin
            if (wr_en) regs[rd] <= result;
            wb_en <= wr_en;
            if (flags_restore_en) begin
                flags <= flags_restore; // Restore wins over a final ADDS
            end else if (adds_en) begin
                flags <= {sum[dw-1],                               // N
                          (sum[dw-1:0] == '0),                     // Z
                          sum[dw],                                 // C
                          (a[dw-1] == b[dw-1]) && (sum[dw-1] != a[dw-1])}; // V
            end
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        wb_reg  <= rd;
        wb_data <= result;
    end

endmodule

/* verilog/inst_decode.sv */
/*
 * Decode stage: registers accepted words and splits their fields
 * Multiply words fire start_mul and hold the stall level until release
 */
`timescale 1ns/1ps

module inst_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    input  logic                          mul_release,
    output logic                          instr_stall,
    output logic                          dec_valid,
    output logic [31:0]                   dec_instr,
    output logic                          start_mul,
    output mcpu_pkg::mul_kind_t           mul_kind,
    output logic [mcpu_pkg::reg_aw-1:0]   dest_reg,
    output logic [mcpu_pkg::reg_aw-1:0]   source_reg,
    output logic [mcpu_pkg::reg_aw-1:0]   src2_reg,
    output logic [mcpu_pkg::imm_w-1:0]    immediate
);

    logic accept;
    logic is_mul;
    logic busy;

    assign accept = instr_valid && !busy; // Source holds its word while busy
    // Upper five opcode bits identify the multiply group
    assign is_mul = (instr[mcpu_pkg::op_hi:mcpu_pkg::op_lo+2] == mcpu_pkg::op_mul_base);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            dec_valid <= 1'b0;
            start_mul <= 1'b0;
        end else begin
            dec_valid <= accept && !is_mul; // Ordinary words go on to issue
            start_mul <= accept && is_mul;  // One-cycle strobe
            if (accept && is_mul) begin
                busy <= 1'b1;
            end else if (mul_release) begin
                busy <= 1'b0; // Sequencer done, open the input again
            end
        end
    end

    // Word register, kept until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) dec_instr <= instr;
    end

    assign instr_stall = busy;

    // Field split of the held word
    assign mul_kind   = mcpu_pkg::mul_kind_t'(dec_instr[mcpu_pkg::op_lo+1:mcpu_pkg::op_lo]);
    assign dest_reg   = dec_instr[mcpu_pkg::rd_hi:mcpu_pkg::rd_lo];
    assign source_reg = dec_instr[mcpu_pkg::rs1_hi:mcpu_pkg::rs1_lo];
    assign src2_reg   = dec_instr[mcpu_pkg::rs2_hi:mcpu_pkg::rs2_lo]; // To the read port
    assign immediate  = dec_instr[mcpu_pkg::imm_hi:mcpu_pkg::imm_lo];

endmodule

/* verilog/issue_select.sv */
/*
 * Issue stage: pipeline register between decode and execute
 * Microcode words take priority while the sequencer holds the mux
 */
`timescale 1ns/1ps

module issue_select (
    input  logic        clk,
    input  logic        rst,
    input  logic        dec_valid,
    input  logic [31:0] dec_instr,
    input  logic        mux_ctrl,
    input  logic [31:0] uc_instr,
    output logic        iss_valid,
    output logic [31:0] iss_instr
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss_valid <= 1'b0;
            iss_instr <= mcpu_pkg::nop_word;
        end else if (mux_ctrl) begin
            iss_valid <= 1'b1;
            iss_instr <= uc_instr; // Sequenced word
        end else if (dec_valid) begin
            iss_valid <= 1'b1;
            iss_instr <= dec_instr;
        end else begin
            // Bubble
            iss_valid <= 1'b0;
            iss_instr <= mcpu_pkg::nop_word;
        end
    end

endmodule

/* verilog/mcpu_core_top.sv */
/*
 * Core slice top: decode, microcode sequencer, issue and execute in order
 */
`timescale 1ns/1ps

module mcpu_core_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    output logic                          instr_stall,
    output logic                          wb_en,
    output logic [mcpu_pkg::reg_aw-1:0]   wb_reg,
    output logic [mcpu_pkg::data_w-1:0]   wb_data,
    output logic [3:0]                    flags
);

    // Decode outputs
    logic                          dec_valid;
    logic [31:0]                   dec_instr;
    logic                          start_mul;
    mcpu_pkg::mul_kind_t           mul_kind;
    logic [mcpu_pkg::reg_aw-1:0]   dest_reg, source_reg, src2_reg;
    logic [mcpu_pkg::imm_w-1:0]    immediate;
    // Sequencer outputs
    logic [31:0]                   uc_instr;
    logic                          mux_ctrl, mul_release, flags_restore_en;
    logic [3:0]                    flags_restore;
    // Issue and register read
    logic                          iss_valid;
    logic [31:0]                   iss_instr;
    logic [mcpu_pkg::data_w-1:0]   read_data_second;

    inst_decode inst_decode_i (
        .clk, .rst, .instr_valid, .instr, .mul_release, .instr_stall, .dec_valid,
        .dec_instr, .start_mul, .mul_kind, .dest_reg, .source_reg, .src2_reg, .immediate
    );

    mul_ucode mul_ucode_i (
        .clk, .rst, .start_mul, .mul_kind, .dest_reg, .source_reg, .immediate,
        .read_data_second, .flags_in(flags), .uc_instr, .mux_ctrl, .mul_release,
        .flags_restore, .flags_restore_en
    );

    issue_select issue_select_i (
        .clk, .rst, .dec_valid, .dec_instr, .mux_ctrl, .uc_instr, .iss_valid, .iss_instr
    );

    exec_stage exec_stage_i (
        .clk, .rst, .iss_valid, .iss_instr, .src2_reg, .flags_restore, .flags_restore_en,
        .read_data_second, .flags, .wb_en, .wb_reg, .wb_data
    );

endmodule

/* verilog/mcpu_pkg.sv */
/*
 * Shared definitions for the multiply core slice
 * Opcodes, instruction field positions, multiply kinds and sequencer states
 */
package mcpu_pkg;

    // Datapath and field widths
    localparam int data_w = 32;
    localparam int reg_aw = 4;  // 16 registers
    localparam int imm_w  = 16;

    // Field positions in the 32-bit word
    localparam int op_hi  = 31;
    localparam int op_lo  = 25;
    localparam int rd_hi  = 24;
    localparam int rd_lo  = 21;
    localparam int rs1_hi = 20;
    localparam int rs1_lo = 17;
    localparam int rs2_hi = 16;
    localparam int rs2_lo = 13;
    localparam int imm_hi = 15;
    localparam int imm_lo = 0;

    // Simple ALU opcodes
    localparam logic [6:0] op_mov  = 7'b0000000; // rd = zext(imm16)
    localparam logic [6:0] op_add  = 7'b0110001;
    localparam logic [6:0] op_sub  = 7'b0110010;
    localparam logic [6:0] op_subi = 7'b0010010;
    localparam logic [6:0] op_adds = 7'b0111001; // Add and set NZCV
    localparam logic [6:0] op_not  = 7'b0110110;
    localparam logic [6:0] op_nop  = 7'b1100100;

    // Multiply group, low two bits carry the kind
    localparam logic [4:0] op_mul_base = 5'b10100;
    localparam logic [6:0] op_muli  = {op_mul_base, 2'd0};
    localparam logic [6:0] op_mulr  = {op_mul_base, 2'd1};
    localparam logic [6:0] op_mulsi = {op_mul_base, 2'd2};
    localparam logic [6:0] op_mulsr = {op_mul_base, 2'd3};

    typedef enum logic [1:0] {muli, mulr, mulsi, mulsr} mul_kind_t;

    typedef enum logic [2:0] {
        st_idle, st_clear, st_mov, st_add, st_fix, st_halt
    } uc_state_t;

    // Idle word, loaded when nothing issues
    localparam logic [31:0] nop_word = {op_nop, 25'b0};

endpackage

/* verilog/mul_ucode.sv */
/*
 * Microcode sequencer for the multiply group
 * Expands MULI/MULR/MULSI/MULSR into MOV, ADD(S), SUB, SUBI and NOT words
 */
`timescale 1ns/1ps

module mul_ucode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_mul,
    input  mcpu_pkg::mul_kind_t           mul_kind,
    input  logic [mcpu_pkg::reg_aw-1:0]   dest_reg,
    input  logic [mcpu_pkg::reg_aw-1:0]   source_reg,
    input  logic [mcpu_pkg::imm_w-1:0]    immediate,
    input  logic [mcpu_pkg::data_w-1:0]   read_data_second,
    input  logic [3:0]                    flags_in,
    output logic [31:0]                   uc_instr,
    output logic                          mux_ctrl,
    output logic                          mul_release,
    output logic [3:0]                    flags_restore,
    output logic                          flags_restore_en
);

    mcpu_pkg::uc_state_t state, state_next;

    logic                          is_imm;
    logic                          is_signed;
    logic [mcpu_pkg::data_w-1:0]   mult_raw;
    logic                          mult_neg;
    logic [mcpu_pkg::data_w-1:0]   mult_mag;

    logic [mcpu_pkg::data_w-1:0]   count;  // Remaining adds
    logic                          neg_q;  // Result needs negation
    logic                          adds_q; // Signed forms issue ADDS
    logic [mcpu_pkg::reg_aw-1:0]   dest_q;
    logic [mcpu_pkg::reg_aw-1:0]   src_q;
    logic [3:0]                    saved_flags;
    logic                          fix_step; // 0 for SUBI, 1 for NOT

    // Multiplier selection and magnitude
    always_comb begin
        is_imm    = (mul_kind == mcpu_pkg::muli) || (mul_kind == mcpu_pkg::mulsi);
        is_signed = (mul_kind == mcpu_pkg::mulsi) || (mul_kind == mcpu_pkg::mulsr);
        if (!is_imm) begin
            mult_raw = read_data_second; // Forwarded by execute if just written
        end else if (is_signed) begin
            mult_raw = {{(mcpu_pkg::data_w-mcpu_pkg::imm_w){immediate[mcpu_pkg::imm_w-1]}},
                        immediate};
        end else begin
            mult_raw = {{(mcpu_pkg::data_w-mcpu_pkg::imm_w){1'b0}}, immediate};
        end
        mult_neg = is_signed && mult_raw[mcpu_pkg::data_w-1];
        mult_mag = mult_neg ? (~mult_raw + 1'b1) : mult_raw; // Two's complement magnitude
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= mcpu_pkg::st_idle;
            fix_step <= 1'b0;
        end else begin
            state    <= state_next;
            fix_step <= (state == mcpu_pkg::st_fix); // Second fix cycle issues NOT
        end
    end

    // Operand and count registers
    always_ff @(posedge clk) begin
        if (state == mcpu_pkg::st_idle && start_mul) begin
            count  <= mult_mag;
            neg_q  <= mult_neg;
            adds_q <= is_signed;
            dest_q <= dest_reg;
            src_q  <= source_reg;
        end else if (state == mcpu_pkg::st_add) begin
            count <= count - 1'b1;
        end
        // Flags sampled once any producer ahead of the multiply has retired
        if (state == mcpu_pkg::st_clear || state == mcpu_pkg::st_mov) begin
            saved_flags <= flags_in;
        end
    end

    always_comb begin
        state_next       = state;
        uc_instr         = mcpu_pkg::nop_word;
        mux_ctrl         = 1'b0;
        mul_release      = 1'b0;
        flags_restore_en = 1'b0;
        case (state)
            mcpu_pkg::st_idle: begin
                if (start_mul) begin
                    state_next = (mult_mag == '0) ? mcpu_pkg::st_clear : mcpu_pkg::st_mov;
                end
            end
            mcpu_pkg::st_clear: begin
                // Zero multiplier, SUB rd,rd,rd
                uc_instr   = {mcpu_pkg::op_sub, dest_q, dest_q, dest_q, 13'b0};
                mux_ctrl   = 1'b1;
                state_next = mcpu_pkg::st_halt;
            end
            mcpu_pkg::st_mov: begin
                uc_instr   = {mcpu_pkg::op_mov, dest_q, 5'b0, 16'b0}; // MOV rd,0
                mux_ctrl   = 1'b1;
                state_next = mcpu_pkg::st_add;
            end
            mcpu_pkg::st_add: begin
                uc_instr = {(adds_q ? mcpu_pkg::op_adds : mcpu_pkg::op_add),
                            dest_q, dest_q, src_q, 13'b0};
                mux_ctrl = 1'b1;
                if (count == 1) begin // Last add
                    state_next = neg_q ? mcpu_pkg::st_fix : mcpu_pkg::st_halt;
                end
            end
            mcpu_pkg::st_fix: begin
                mux_ctrl = 1'b1;
                if (!fix_step) begin
                    uc_instr = {mcpu_pkg::op_subi, dest_q, dest_q, 1'b0, 16'd1};
                end else begin
                    uc_instr   = {mcpu_pkg::op_not, dest_q, dest_q, 17'b0}; // ~(x-1) = -x
                    state_next = mcpu_pkg::st_halt;
                end
            end
            mcpu_pkg::st_halt: begin
                mul_release      = 1'b1; // Hand the input back to decode
                flags_restore_en = 1'b1;
                state_next       = mcpu_pkg::st_idle;
            end
            default: state_next = mcpu_pkg::st_idle;
        endcase
    end

    assign flags_restore = saved_flags;

endmodule
